// File: rtl/ooo_cfg_pkg.sv
/*
  Widths and ALU operation encoding for the issue stage.
  Register index width must cover PHYS_REG_NUM.
  Shifts take only the low SHAMT_WIDTH bits of operand b.
  slt compares signed and returns 1 or 0 in the full result width.
*/
package ooo_cfg_pkg;

	// operand and result width
	localparam int REG_VAL_WIDTH = 32;

	// physical register file size and index width
	localparam int PHYS_REG_NUM = 32;
	localparam int PHYS_REG_IDX_WIDTH = 5;

	// reorder tag carried from dispatch to the CDB
	localparam int TAG_WIDTH = 6;

	// shift amount bits taken from operand b
	localparam int SHAMT_WIDTH = $clog2(REG_VAL_WIDTH);

	// integer ALU operations
	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR  = 3'd3,
		ALU_XOR = 3'd4,
		ALU_SLL = 3'd5,
		ALU_SRL = 3'd6,
		// signed less-than, result is 0 or 1
		ALU_SLT = 3'd7
	} alu_op_t;

endpackage

// File: rtl/ooo_msg_pkg.sv
/*
  Packed messages passed between the issue stage blocks.
  Widths come from ooo_cfg_pkg.
  In rs_entry_t the immediate is already folded into operand 2.
*/
package ooo_msg_pkg;

	// renamed instruction from the producer
	typedef struct packed {
		ooo_cfg_pkg::alu_op_t                           op;
		logic                                           use_imm;
		logic [ooo_cfg_pkg::PHYS_REG_IDX_WIDTH-1:0]     dst;
		logic [ooo_cfg_pkg::PHYS_REG_IDX_WIDTH-1:0]     src1;
		logic [ooo_cfg_pkg::PHYS_REG_IDX_WIDTH-1:0]     src2;
		logic [ooo_cfg_pkg::REG_VAL_WIDTH-1:0]          imm;
		logic [ooo_cfg_pkg::TAG_WIDTH-1:0]              tag;
	} inst_t;

	// source operand as seen at dispatch, forwarded from the CDB if needed
	typedef struct packed {
		logic                                           ready;
		logic [ooo_cfg_pkg::REG_VAL_WIDTH-1:0]          value;
	} src_read_t;

	// one reservation station slot
	typedef struct packed {
		logic                                           valid;
		ooo_cfg_pkg::alu_op_t                           op;
		logic [ooo_cfg_pkg::PHYS_REG_IDX_WIDTH-1:0]     dst;
		logic [ooo_cfg_pkg::TAG_WIDTH-1:0]              tag;
		logic [ooo_cfg_pkg::PHYS_REG_IDX_WIDTH-1:0]     src1;
		logic                                           src1_ready;
		logic [ooo_cfg_pkg::REG_VAL_WIDTH-1:0]          src1_value;
		logic [ooo_cfg_pkg::PHYS_REG_IDX_WIDTH-1:0]     src2;
		logic                                           src2_ready;
		logic [ooo_cfg_pkg::REG_VAL_WIDTH-1:0]          src2_value;
	} rs_entry_t;

	// ALU input, one per functional unit
	typedef struct packed {
		logic                                           valid;
		ooo_cfg_pkg::alu_op_t                           op;
		logic [ooo_cfg_pkg::REG_VAL_WIDTH-1:0]          a;
		logic [ooo_cfg_pkg::REG_VAL_WIDTH-1:0]          b;
		logic [ooo_cfg_pkg::PHYS_REG_IDX_WIDTH-1:0]     dst;
		logic [ooo_cfg_pkg::TAG_WIDTH-1:0]              tag;
	} issue_msg_t;

	// one CDB lane, valid for a single cycle
	typedef struct packed {
		logic                                           valid;
		logic [ooo_cfg_pkg::PHYS_REG_IDX_WIDTH-1:0]     dst;
		logic [ooo_cfg_pkg::REG_VAL_WIDTH-1:0]          value;
		logic [ooo_cfg_pkg::TAG_WIDTH-1:0]              tag;
	} cdb_msg_t;

endpackage

// File: rtl/phys_reg_file.sv
/*
  Physical register values and ready bits.
  After reset every register holds zero and is ready.
  Source reads are combinational and forward same-cycle CDB results.
  Same register hit by CDB and dispatch in one cycle: the CDB value is
  written but the register stays busy for the new producer.
  Two CDB lanes never target the same register (producer reuse rule).
*/
module phys_reg_file #(
	parameter int FU_NUM = 2
) (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    inst_valid,
	input  ooo_msg_pkg::inst_t      inst,
	input  ooo_msg_pkg::cdb_msg_t   cdb [FU_NUM],
	output ooo_msg_pkg::src_read_t  src_rd [2]
);

	localparam int W = ooo_cfg_pkg::REG_VAL_WIDTH;
	localparam int NREG = ooo_cfg_pkg::PHYS_REG_NUM;
	localparam int RIDX = ooo_cfg_pkg::PHYS_REG_IDX_WIDTH;

	logic [W-1:0]    reg_value [NREG];
	logic [NREG-1:0] reg_ready;

	// the two source indices of the incoming instruction
	logic [RIDX-1:0] src_idx [2];

	assign src_idx[0] = inst.src1;
	assign src_idx[1] = inst.src2;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int r = 0; r < NREG; r++) begin
				reg_value[r] <= '0;
			end
			reg_ready <= '1;
		end else begin
			// results coming back mark their register ready
			for (int l = 0; l < FU_NUM; l++) begin
				if (cdb[l].valid) begin
					reg_value[cdb[l].dst] <= cdb[l].value;
					reg_ready[cdb[l].dst] <= 1'b1;
				end
			end
			// new producer makes dst busy, placed last so it wins
			if (inst_valid) begin
				reg_ready[inst.dst] <= 1'b0;
			end
		end
	end

	// source read with CDB bypass
	always_comb begin
		for (int s = 0; s < 2; s++) begin
			src_rd[s].ready = reg_ready[src_idx[s]];
			src_rd[s].value = reg_value[src_idx[s]];
			for (int l = 0; l < FU_NUM; l++) begin
				if (cdb[l].valid && cdb[l].dst == src_idx[s]) begin
					src_rd[s].ready = 1'b1;
					src_rd[s].value = cdb[l].value;
				end
			end
		end
	end

endmodule

// File: rtl/rs_entries.sv
/*
  Reservation station storage with operand capture and CDB wakeup.
  The controller picks alloc_idx and the grants; this block only moves data.
  With use_imm set, the immediate becomes operand b and is ready at once.
  Issue messages are registered, one per ALU, valid for one cycle.
  A granted entry is freed at the same edge and may be reallocated next cycle.
*/
module rs_entries #(
	parameter int RS_ENTRIES = 8,
	parameter int FU_NUM = 2
) (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     inst_valid,
	input  ooo_msg_pkg::inst_t       inst,
	input  ooo_msg_pkg::src_read_t   src_rd [2],
	input  logic [IDX_W-1:0]         alloc_idx,
	input  logic [FU_NUM-1:0]        grant_valid,
	input  logic [IDX_W-1:0]         grant_idx [FU_NUM],
	input  ooo_msg_pkg::cdb_msg_t    cdb [FU_NUM],
	output logic [RS_ENTRIES-1:0]    entry_valid,
	output logic [RS_ENTRIES-1:0]    entry_ready,
	output ooo_msg_pkg::issue_msg_t  issue [FU_NUM]
);

	localparam int IDX_W = (RS_ENTRIES <= 1) ? 1 : $clog2(RS_ENTRIES);

	ooo_msg_pkg::rs_entry_t entries [RS_ENTRIES];
	ooo_msg_pkg::rs_entry_t new_entry;

	// entry image built from the dispatched instruction
	always_comb begin
		new_entry.valid      = 1'b1;
		new_entry.op         = inst.op;
		new_entry.dst        = inst.dst;
		new_entry.tag        = inst.tag;
		new_entry.src1       = inst.src1;
		new_entry.src1_ready = src_rd[0].ready;
		new_entry.src1_value = src_rd[0].value;
		new_entry.src2       = inst.src2;
		// immediate replaces the second register operand
		new_entry.src2_ready = inst.use_imm ? 1'b1 : src_rd[1].ready;
		new_entry.src2_value = inst.use_imm ? inst.imm : src_rd[1].value;
	end

	always_comb begin
		for (int i = 0; i < RS_ENTRIES; i++) begin
			entry_valid[i] = entries[i].valid;
			entry_ready[i] = entries[i].src1_ready && entries[i].src2_ready;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < RS_ENTRIES; i++) begin
				entries[i].valid <= 1'b0;
			end
		end else begin
			// wakeup, only sources still waiting can capture
			for (int i = 0; i < RS_ENTRIES; i++) begin
				for (int l = 0; l < FU_NUM; l++) begin
					if (cdb[l].valid && entries[i].valid) begin
						if (!entries[i].src1_ready && cdb[l].dst == entries[i].src1) begin
							entries[i].src1_ready <= 1'b1;
							entries[i].src1_value <= cdb[l].value;
						end
						if (!entries[i].src2_ready && cdb[l].dst == entries[i].src2) begin
							entries[i].src2_ready <= 1'b1;
							entries[i].src2_value <= cdb[l].value;
						end
					end
				end
			end
			// granted entries leave the station
			for (int f = 0; f < FU_NUM; f++) begin
				if (grant_valid[f]) begin
					entries[grant_idx[f]].valid <= 1'b0;
				end
			end
			// alloc_idx always points at a free slot, never a granted one
			if (inst_valid) begin
				entries[alloc_idx] <= new_entry;
			end
		end
	end

	// registered issue towards the ALUs
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int f = 0; f < FU_NUM; f++) begin
				issue[f].valid <= 1'b0;
			end
		end else begin
			for (int f = 0; f < FU_NUM; f++) begin
				issue[f].valid <= grant_valid[f];
				issue[f].op    <= entries[grant_idx[f]].op;
				issue[f].a     <= entries[grant_idx[f]].src1_value;
				issue[f].b     <= entries[grant_idx[f]].src2_value;
				issue[f].dst   <= entries[grant_idx[f]].dst;
				issue[f].tag   <= entries[grant_idx[f]].tag;
			end
		end
	end

endmodule

// File: rtl/issue_ctrl.sv
/*
  Allocation and selection control for the reservation station.
  alloc_idx is the lowest free entry; it is meaningless while rs_full is high.
  rs_full also rises when the last free entry is being filled this cycle.
  Up to FU_NUM distinct ready entries are granted per cycle, searched from a
  pointer that advances by one after every cycle with at least one grant.
*/
module issue_ctrl #(
	parameter int RS_ENTRIES = 8,
	parameter int FU_NUM = 2
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   inst_valid,
	input  logic [RS_ENTRIES-1:0]  entry_valid,
	input  logic [RS_ENTRIES-1:0]  entry_ready,
	output logic [IDX_W-1:0]       alloc_idx,
	output logic                   rs_full,
	output logic [FU_NUM-1:0]      grant_valid,
	output logic [IDX_W-1:0]       grant_idx [FU_NUM]
);

	localparam int IDX_W = (RS_ENTRIES <= 1) ? 1 : $clog2(RS_ENTRIES);
	localparam int CNT_W = $clog2(RS_ENTRIES + 1);

	logic [IDX_W-1:0] ptr;
	logic [CNT_W-1:0] free_cnt;

	// lowest free entry and number of free entries
	always_comb begin
		alloc_idx = '0;
		free_cnt = '0;
		for (int i = RS_ENTRIES - 1; i >= 0; i--) begin
			if (!entry_valid[i]) begin
				alloc_idx = IDX_W'(i);
				free_cnt = free_cnt + 1'b1;
			end
		end
	end

	assign rs_full = (free_cnt == '0) || (free_cnt == CNT_W'(1) && inst_valid);

	// rotating priority multi-grant
	always_comb begin
		int unsigned n;
		int unsigned idx;
		n = 0;
		grant_valid = '0;
		for (int f = 0; f < FU_NUM; f++) begin
			grant_idx[f] = '0;
		end
		for (int k = 0; k < RS_ENTRIES; k++) begin
			idx = (int'(ptr) + k) % RS_ENTRIES;
			if (entry_valid[idx] && entry_ready[idx] && n < FU_NUM) begin
				grant_valid[n] = 1'b1;
				grant_idx[n] = IDX_W'(idx);
				n = n + 1;
			end
		end
	end

	// pointer moves only when something issued
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ptr <= '0;
		end else if (|grant_valid) begin
			ptr <= (ptr == IDX_W'(RS_ENTRIES - 1)) ? '0 : ptr + 1'b1;
		end
	end

endmodule

// File: rtl/alu_unit.sv
/*
  Two-stage pipelined integer ALU feeding one CDB lane.
  Accepts one issue message per cycle, no stall.
  Result appears on the lane two edges after the issue message.
  Shift amounts use only the low bits of operand b.
*/
module alu_unit (
	input  logic                     clk,
	input  logic                     reset,
	input  ooo_msg_pkg::issue_msg_t  issue,
	output ooo_msg_pkg::cdb_msg_t    result
);

	localparam int W = ooo_cfg_pkg::REG_VAL_WIDTH;
	localparam int SH = ooo_cfg_pkg::SHAMT_WIDTH;

	// stage one holding register
	ooo_msg_pkg::issue_msg_t s1;
	logic [W-1:0]            alu_out;
	logic                    slt_bit;

	assign slt_bit = $signed(s1.a) < $signed(s1.b);

	always_comb begin
		case (s1.op)
			ooo_cfg_pkg::ALU_ADD: alu_out = s1.a + s1.b;
			ooo_cfg_pkg::ALU_SUB: alu_out = s1.a - s1.b;
			ooo_cfg_pkg::ALU_AND: alu_out = s1.a & s1.b;
			ooo_cfg_pkg::ALU_OR:  alu_out = s1.a | s1.b;
			ooo_cfg_pkg::ALU_XOR: alu_out = s1.a ^ s1.b;
			ooo_cfg_pkg::ALU_SLL: alu_out = s1.a << s1.b[SH-1:0];
			ooo_cfg_pkg::ALU_SRL: alu_out = s1.a >> s1.b[SH-1:0];
			ooo_cfg_pkg::ALU_SLT: alu_out = {{(W-1){1'b0}}, slt_bit};
			default:              alu_out = '0;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			s1.valid <= 1'b0;
			result.valid <= 1'b0;
		end else begin
			// stage one, capture operands
			s1 <= issue;
			// stage two, compute and drive the lane
			result.valid <= s1.valid;
			result.dst   <= s1.dst;
			result.value <= alu_out;
			result.tag   <= s1.tag;
		end
	end

endmodule

// File: rtl/issue_core_top.sv
/*
  Issue stage top: register file, reservation station, controller, ALUs.
  inst_valid is a one-cycle strobe with no back-pressure; the producer must
  not strobe while rs_full is high and must not reuse a destination register
  before its result has been broadcast.
  Each cdb lane carries at most one result per cycle.
*/
module issue_core_top #(
	parameter int RS_ENTRIES = 8,
	parameter int FU_NUM = 2
) (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   inst_valid,
	input  ooo_msg_pkg::inst_t     inst,
	output logic                   rs_full,
	output ooo_msg_pkg::cdb_msg_t  cdb [FU_NUM]
);

	localparam int IDX_W = (RS_ENTRIES <= 1) ? 1 : $clog2(RS_ENTRIES);

	ooo_msg_pkg::src_read_t  src_rd [2];
	ooo_msg_pkg::issue_msg_t issue [FU_NUM];
	logic [RS_ENTRIES-1:0]   entry_valid;
	logic [RS_ENTRIES-1:0]   entry_ready;
	logic [IDX_W-1:0]        alloc_idx;
	logic [FU_NUM-1:0]       grant_valid;
	logic [IDX_W-1:0]        grant_idx [FU_NUM];

	phys_reg_file #(.FU_NUM(FU_NUM)) u_prf (
		.clk        (clk),
		.reset      (reset),
		.inst_valid (inst_valid),
		.inst       (inst),
		.cdb        (cdb),
		.src_rd     (src_rd)
	);

	issue_ctrl #(.RS_ENTRIES(RS_ENTRIES), .FU_NUM(FU_NUM)) u_ctrl (
		.clk         (clk),
		.reset       (reset),
		.inst_valid  (inst_valid),
		.entry_valid (entry_valid),
		.entry_ready (entry_ready),
		.alloc_idx   (alloc_idx),
		.rs_full     (rs_full),
		.grant_valid (grant_valid),
		.grant_idx   (grant_idx)
	);

	rs_entries #(.RS_ENTRIES(RS_ENTRIES), .FU_NUM(FU_NUM)) u_rs (
		.clk         (clk),
		.reset       (reset),
		.inst_valid  (inst_valid),
		.inst        (inst),
		.src_rd      (src_rd),
		.alloc_idx   (alloc_idx),
		.grant_valid (grant_valid),
		.grant_idx   (grant_idx),
		.cdb         (cdb),
		.entry_valid (entry_valid),
		.entry_ready (entry_ready),
		.issue       (issue)
	);

	// one ALU per CDB lane
	for (genvar f = 0; f < FU_NUM; f++) begin : g_alu
		alu_unit u_alu (
			.clk    (clk),
			.reset  (reset),
			.issue  (issue[f]),
			.result (cdb[f])
		);
	end

endmodule

// File: sim/issue_core_tb.sv
/*
  Testbench for the issue stage, RS_ENTRIES 8 and FU_NUM 2.
  Tags are never reused, so a run is limited to 2**TAG_WIDTH instructions.
  rs_full is checked two cycles late, once the CDB shows which entries left.
  The producer model waits on rs_full and on its own free register list.
*/
module issue_core_tb;

	localparam int W = ooo_cfg_pkg::REG_VAL_WIDTH;
	localparam int RIDX = ooo_cfg_pkg::PHYS_REG_IDX_WIDTH;
	localparam int NREG = ooo_cfg_pkg::PHYS_REG_NUM;
	localparam int NUM_TAGS = 1 << ooo_cfg_pkg::TAG_WIDTH;
	localparam int RS_N = 8;
	localparam int FU_N = 2;
	localparam int NUM_INST = 63;
	localparam int TIMEOUT_CYCLES = 40 * NUM_INST + 200;

	logic                  clk;
	logic                  reset;
	logic                  inst_valid;
	ooo_msg_pkg::inst_t    inst;
	logic                  rs_full;
	ooo_msg_pkg::cdb_msg_t cdb [FU_N];

	// producer and reference model state
	int             seed;
	int             next_tag;
	int             done_cnt;
	int             results_seen;
	int             disp_done;
	int             mismatch_cnt;
	int             other_cnt;
	int             dual_cnt;
	int             full_seen;
	int             cycle_cnt;
	logic [W-1:0]   model_regs [NREG];
	bit             reg_busy [NREG];
	logic [RIDX-1:0] free_regs [$];
	logic [RIDX-1:0] last_dst;
	logic [W-1:0]   exp_val [NUM_TAGS];
	logic [RIDX-1:0] exp_dst [NUM_TAGS];
	bit             tag_sent [NUM_TAGS];
	bit             tag_done [NUM_TAGS];
	// rs_full history, index 1 is two cycles old
	bit             hist_full [2];
	bit             hist_iv [2];
	int             hist_disp [2];

	issue_core_top #(.RS_ENTRIES(RS_N), .FU_NUM(FU_N)) UUT (
		.clk        (clk),
		.reset      (reset),
		.inst_valid (inst_valid),
		.inst       (inst),
		.rs_full    (rs_full),
		.cdb        (cdb)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// integer op semantics, shifts by the low 5 bits of b
	function automatic logic [W-1:0] ref_alu(input ooo_cfg_pkg::alu_op_t op,
			input logic [W-1:0] a, input logic [W-1:0] b);
		case (op)
			ooo_cfg_pkg::ALU_ADD: return a + b;
			ooo_cfg_pkg::ALU_SUB: return a - b;
			ooo_cfg_pkg::ALU_AND: return a & b;
			ooo_cfg_pkg::ALU_OR:  return a | b;
			ooo_cfg_pkg::ALU_XOR: return a ^ b;
			ooo_cfg_pkg::ALU_SLL: return a << b[4:0];
			ooo_cfg_pkg::ALU_SRL: return a >> b[4:0];
			default:              return ($signed(a) < $signed(b)) ? W'(1) : W'(0);
		endcase
	endfunction

	// in-order execution on the model registers
	function automatic logic [W-1:0] predict(input ooo_msg_pkg::inst_t i);
		logic [W-1:0] b;
		logic [W-1:0] r;
		b = i.use_imm ? i.imm : model_regs[i.src2];
		r = ref_alu(i.op, model_regs[i.src1], b);
		model_regs[i.dst] = r;
		return r;
	endfunction

	// a source with no producer in flight
	function automatic logic [RIDX-1:0] pick_ready_reg();
		logic [RIDX-1:0] r;
		r = $random(seed);
		while (reg_busy[r]) r = r + 1'b1;
		return r;
	endfunction

	function automatic ooo_cfg_pkg::alu_op_t rand_op();
		logic [2:0] v;
		v = $random(seed);
		return ooo_cfg_pkg::alu_op_t'(v);
	endfunction

	// one strobe, held back while the station is full or no dst is free
	task automatic send_inst(input ooo_cfg_pkg::alu_op_t op, input bit use_imm,
			input logic [RIDX-1:0] s1, input logic [RIDX-1:0] s2, input logic [W-1:0] imm);
		ooo_msg_pkg::inst_t i;
		@(negedge clk);
		while (rs_full || free_regs.size() == 0) begin
			@(posedge clk);
			inst_valid <= 1'b0;
			@(negedge clk);
		end
		i.op = op;
		i.use_imm = use_imm;
		i.src1 = s1;
		i.src2 = s2;
		i.imm = imm;
		i.dst = free_regs.pop_front();
		i.tag = next_tag[ooo_cfg_pkg::TAG_WIDTH-1:0];
		exp_dst[next_tag] = i.dst;
		exp_val[next_tag] = predict(i);
		tag_sent[next_tag] = 1'b1;
		reg_busy[i.dst] = 1'b1;
		last_dst = i.dst;
		next_tag++;
		@(posedge clk);
		inst_valid <= 1'b1;
		inst <= i;
	endtask

	task automatic go_idle();
		@(posedge clk);
		inst_valid <= 1'b0;
	endtask

	task automatic check_result(input ooo_msg_pkg::cdb_msg_t got);
		if (!tag_sent[got.tag]) begin
			other_cnt++;
			$display("lane result at %0t has tag %0d that was never dispatched", $time, got.tag);
		end else if (tag_done[got.tag]) begin
			other_cnt++;
			$display("tag %0d appeared a second time at %0t", got.tag, $time);
		end else begin
			if (got.dst !== exp_dst[got.tag] || got.value !== exp_val[got.tag]) begin
				mismatch_cnt++;
				$display("MISMATCH at %0t: tag %0d dst %0d value %h, expected dst %0d value %h",
					$time, got.tag, got.dst, got.value, exp_dst[got.tag], exp_val[got.tag]);
			end
			tag_done[got.tag] = 1'b1;
			done_cnt++;
			// register may be handed out again
			reg_busy[exp_dst[got.tag]] = 1'b0;
			free_regs.push_back(exp_dst[got.tag]);
		end
	endtask

	task automatic check_full(input bit got, input bit exp);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("MISMATCH at %0t: rs_full two cycles back was %0b, expected %0b",
				$time, got, exp);
		end
	endtask

	// compare process, sampled mid-cycle where outputs are stable
	always @(negedge clk) begin
		int occ;
		int lanes;
		lanes = 0;
		for (int l = 0; l < FU_N; l++) begin
			if (cdb[l].valid === 1'b1) begin
				check_result(cdb[l]);
				lanes++;
			end
		end
		results_seen += lanes;
		if (lanes == FU_N) dual_cnt++;
		if (rs_full) full_seen++;
		// a result seen now left the station two edges ago
		occ = hist_disp[1] - results_seen;
		check_full(hist_full[1], occ >= RS_N || (occ == RS_N - 1 && hist_iv[1]));
		hist_full[1] = hist_full[0];
		hist_iv[1] = hist_iv[0];
		hist_disp[1] = hist_disp[0];
		hist_full[0] = rs_full;
		hist_iv[0] = inst_valid;
		hist_disp[0] = disp_done;
		if (inst_valid) disp_done++;
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		other_cnt++;
		$display("timeout after %0d cycles with %0d of %0d results seen",
			cycle_cnt, done_cnt, NUM_INST);
		// name the results that got lost
		for (int t = 0; t < next_tag; t++) begin
			if (!tag_done[t]) begin
				other_cnt++;
				$display("tag %0d never appeared on any lane", t);
			end
		end
		$display("summary: %0d value mismatches, %0d other errors", mismatch_cnt, other_cnt);
		$display("test failed");
		$finish;
	end

	initial begin
		logic [RIDX-1:0] head;
		logic [RIDX-1:0] load_dst [8];
		reset = 1'b1;
		inst_valid = 1'b0;
		inst = '0;
		seed = 31;
		next_tag = 0;
		done_cnt = 0;
		results_seen = 0;
		disp_done = 0;
		mismatch_cnt = 0;
		other_cnt = 0;
		dual_cnt = 0;
		full_seen = 0;
		last_dst = '0;
		for (int r = 0; r < NREG; r++) begin
			model_regs[r] = '0;
			reg_busy[r] = 1'b0;
			free_regs.push_back(RIDX'(r));
		end
		for (int h = 0; h < 2; h++) begin
			hist_full[h] = 1'b0;
			hist_iv[h] = 1'b0;
			hist_disp[h] = 0;
		end
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		// quiet period, no results or full flag expected
		repeat (5) @(posedge clk);
		// every op kind, immediate form first so registers pick up values
		for (int k = 0; k < 8; k++) begin
			send_inst(ooo_cfg_pkg::alu_op_t'(k), 1'b1, pick_ready_reg(), '0, $random(seed));
			load_dst[k] = last_dst;
		end
		go_idle();
		wait (done_cnt == next_tag);
		// register form, a from the add and sub results, b from the or and xor results
		for (int k = 0; k < 8; k++) begin
			send_inst(ooo_cfg_pkg::alu_op_t'(k), 1'b0, load_dst[k % 2],
				load_dst[3 + (k / 2) % 2], '0);
		end
		go_idle();
		wait (done_cnt == next_tag);
		// three back to back dependent chains
		for (int c = 0; c < 3; c++) begin
			send_inst(rand_op(), 1'b1, pick_ready_reg(), '0, $random(seed));
			for (int k = 0; k < 3; k++) begin
				send_inst(rand_op(), k[0], last_dst, pick_ready_reg(), $random(seed));
			end
		end
		go_idle();
		wait (done_cnt == next_tag);
		// long head chain, then eight waiters that fill the station
		send_inst(ooo_cfg_pkg::ALU_ADD, 1'b1, pick_ready_reg(), '0, $random(seed));
		send_inst(ooo_cfg_pkg::ALU_XOR, 1'b1, last_dst, '0, $random(seed));
		send_inst(ooo_cfg_pkg::ALU_SUB, 1'b1, last_dst, '0, $random(seed));
		head = last_dst;
		for (int k = 0; k < 8; k++) begin
			send_inst(rand_op(), 1'b1, head, '0, $random(seed));
		end
		go_idle();
		wait (done_cnt == next_tag);
		// independent stream to load both lanes
		for (int k = 0; k < 24; k++) begin
			send_inst(rand_op(), $random(seed), pick_ready_reg(), pick_ready_reg(),
				$random(seed));
		end
		go_idle();
		wait (done_cnt == NUM_INST);
		// catch late duplicates
		repeat (20) @(posedge clk);
		if (dual_cnt == 0) begin
			other_cnt++;
			$display("both ALU lanes never delivered in the same cycle");
		end
		if (full_seen == 0) begin
			other_cnt++;
			$display("rs_full never rose while the station was filled");
		end
		$display("summary: %0d value mismatches, %0d other errors", mismatch_cnt, other_cnt);
		if (mismatch_cnt + other_cnt == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// File: flist.f
rtl/ooo_cfg_pkg.sv
rtl/ooo_msg_pkg.sv
rtl/phys_reg_file.sv
rtl/rs_entries.sv
rtl/issue_ctrl.sv
rtl/alu_unit.sv
rtl/issue_core_top.sv
sim/issue_core_tb.sv

// File: Bender.yml
package:
  name: issue_core

sources:
  - files:
      - rtl/ooo_cfg_pkg.sv
      - rtl/ooo_msg_pkg.sv
      - rtl/phys_reg_file.sv
      - rtl/rs_entries.sv
      - rtl/issue_ctrl.sv
      - rtl/alu_unit.sv
      - rtl/issue_core_top.sv
  - target: simulation
    files:
      - sim/issue_core_tb.sv
